/* common/mario_pkg.sv */
`default_nettype none

package mario_pkg;

    typedef logic [9:0] pos_x_t;
    typedef logic [8:0] pos_y_t;
    typedef logic signed [9:0] speed_x_t;
    // tenths of a pixel per cycle
    typedef logic signed [12:0] speed_y_t;
    typedef logic [4:0] key_vec_t;

    typedef enum logic [2:0] {
        st_initial  = 3'd0,
        st_flying   = 3'd1,
        st_jumping  = 3'd2,
        st_walking  = 3'd3,
        st_standing = 3'd4,
        st_dying    = 3'd5,
        st_climbing = 3'd6
    } motion_state_t;

    // bit positions in key_vec_t
    localparam int key_up    = 0;
    localparam int key_left  = 1;
    localparam int key_right = 2;
    localparam int key_down  = 3;
    localparam int key_jump  = 4;

    localparam pos_x_t hero_width  = 10'd34;
    localparam pos_y_t hero_height = 9'd36;

    localparam pos_x_t start_x = 10'd450;
    localparam pos_y_t start_y = 9'd425;

    localparam speed_x_t walk_speed  = 10'sd3;
    localparam pos_y_t   climb_speed = 9'd3;
    localparam speed_y_t jump_speed  = 13'sd45;
    localparam speed_y_t gravity     = 13'sd3;

    localparam pos_y_t border_top    = 9'd5;
    localparam pos_y_t border_bottom = 9'd461;
    localparam pos_x_t border_left   = 10'd5;
    localparam pos_x_t border_right  = 10'd640;

    // platform rectangles, top-left (lx, ly) to bottom-right (rx, ry)
    localparam int num_platforms = 6;

    localparam pos_x_t platform_lx [num_platforms] =
        '{10'd250, 10'd0, 10'd49, 10'd0, 10'd49, 10'd0};
    localparam pos_y_t platform_ly [num_platforms] =
        '{9'd53, 9'd115, 9'd197, 9'd286, 9'd376, 9'd461};
    localparam pos_x_t platform_rx [num_platforms] =
        '{10'd388, 10'd591, 10'd640, 10'd591, 10'd640, 10'd640};
    localparam pos_y_t platform_ry [num_platforms] =
        '{9'd70, 9'd131, 9'd213, 9'd302, 9'd393, 9'd479};

    // ladder rectangles
    localparam int num_ladders = 5;

    localparam pos_x_t ladder_lx [num_ladders] =
        '{10'd339, 10'd541, 10'd48, 10'd546, 10'd53};
    localparam pos_y_t ladder_ly [num_ladders] =
        '{9'd15, 9'd77, 9'd159, 9'd248, 9'd338};
    localparam pos_x_t ladder_rx [num_ladders] =
        '{10'd353, 10'd555, 10'd62, 10'd560, 10'd67};
    localparam pos_y_t ladder_ry [num_ladders] =
        '{9'd81, 9'd163, 9'd252, 9'd342, 9'd427};

endpackage

`default_nettype wire

/* rtl/mario_top.sv */
`default_nettype none

module mario_top (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            start,
    input  wire                            over,
    input  wire mario_pkg::key_vec_t       keys,
    output wire mario_pkg::pos_x_t         x,
    output wire mario_pkg::pos_y_t         y,
    output wire mario_pkg::motion_state_t  state
);

    logic blocked_left;
    logic blocked_right;
    logic on_ground;
    logic on_ladder;
    logic falling;

    // position feeds back into the contact flags
    scene_map scene_map_inst (
        .x             (x),
        .y             (y),
        .blocked_left  (blocked_left),
        .blocked_right (blocked_right),
        .on_ground     (on_ground),
        .on_ladder     (on_ladder)
    );

    motion_fsm motion_fsm_inst (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .over          (over),
        .keys          (keys),
        .blocked_left  (blocked_left),
        .blocked_right (blocked_right),
        .on_ground     (on_ground),
        .on_ladder     (on_ladder),
        .falling       (falling),
        .state         (state)
    );

    vertical_motion vertical_motion_inst (
        .clk     (clk),
        .rst     (rst),
        .state   (state),
        .keys    (keys),
        .x       (x),
        .y       (y),
        .falling (falling)
    );

    horizontal_motion horizontal_motion_inst (
        .clk   (clk),
        .rst   (rst),
        .state (state),
        .keys  (keys),
        .x     (x)
    );

endmodule

`default_nettype wire

/* rtl/motion_fsm.sv */
`default_nettype none

module motion_fsm (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       start,
    input  wire                       over,
    input  wire mario_pkg::key_vec_t  keys,
    input  wire                       blocked_left,
    input  wire                       blocked_right,
    input  wire                       on_ground,
    input  wire                       on_ladder,
    input  wire                       falling,
    output mario_pkg::motion_state_t  state
);
    import mario_pkg::*;

    motion_state_t state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_initial;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;

        case (state)
            st_initial: begin
                if (start) begin
                    state_next = st_standing;
                end
            end

            st_standing, st_walking: begin
                if (!on_ground) begin
                    state_next = st_flying;
                end else if (keys[key_jump]) begin
                    state_next = st_jumping;
                end else if ((keys[key_up] || keys[key_down]) && on_ladder) begin
                    state_next = st_climbing;
                end else if (keys[key_left] || keys[key_right]) begin
                    state_next = st_walking;
                end else begin
                    state_next = st_standing;
                end
            end

            // impulse is applied in this single cycle
            st_jumping: state_next = st_flying;

            st_flying: begin
                if (on_ground && falling) begin
                    state_next = st_standing;
                end
            end

            st_climbing: begin
                if (keys[key_jump] && on_ground) begin
                    state_next = st_jumping;
                end else if ((keys[key_left] && !blocked_left) ||
                             (keys[key_right] && !blocked_right)) begin
                    state_next = st_walking;
                end else if (on_ladder) begin
                    state_next = st_climbing;
                end else begin
                    state_next = st_standing;
                end
            end

            // only rst leaves dying
            st_dying: state_next = st_dying;

            default: state_next = st_initial;
        endcase

        if (over && state != st_initial) begin
            state_next = st_dying;
        end
    end

    a_over_kills: assert property (
        @(posedge clk) disable iff (rst)
        (over && state != st_initial) |=> (state == st_dying)
    );

    a_jump_one_cycle: assert property (
        @(posedge clk) disable iff (rst)
        (state == st_jumping) |=> (state != st_jumping)
    );

endmodule

`default_nettype wire

/* rtl/physics/horizontal_motion.sv */
`default_nettype none

module horizontal_motion (
    input  wire                            clk,
    input  wire                            rst,
    input  wire mario_pkg::motion_state_t  state,
    input  wire mario_pkg::key_vec_t       keys,
    output mario_pkg::pos_x_t              x
);
    import mario_pkg::*;

    speed_x_t speed_x;
    speed_x_t walk_step;

    // move and clamp to the screen
    function automatic pos_x_t step_x(pos_x_t pos, speed_x_t step);
        int nx;
        nx = int'(pos) + int'(step);
        if (nx < int'(border_left)) begin
            return border_left;
        end
        if (nx > int'(border_right) - int'(hero_width)) begin
            return border_right - hero_width;
        end
        return pos_x_t'(nx);
    endfunction

    // left wins when both are held
    always_comb begin
        if (keys[key_left]) begin
            walk_step = -walk_speed;
        end else if (keys[key_right]) begin
            walk_step = walk_speed;
        end else begin
            walk_step = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || state == st_initial) begin
            x       <= start_x;
            speed_x <= '0;
        end else begin
            case (state)
                st_walking: begin
                    x       <= step_x(x, walk_step);
                    speed_x <= walk_step;
                end
                // keeps the speed it left the ground with
                st_flying: x <= step_x(x, speed_x);
                default:   speed_x <= '0;
            endcase
        end
    end

    a_x_above_left: assert property (
        @(posedge clk) disable iff (rst)
        x >= border_left
    );

endmodule

`default_nettype wire

/* rtl/physics/vertical_motion.sv */
`default_nettype none

module vertical_motion (
    input  wire                            clk,
    input  wire                            rst,
    input  wire mario_pkg::motion_state_t  state,
    input  wire mario_pkg::key_vec_t       keys,
    input  wire mario_pkg::pos_x_t         x,
    output mario_pkg::pos_y_t              y,
    output logic                           falling
);
    import mario_pkg::*;

    speed_y_t speed_y;
    pos_y_t   y_fly;
    speed_y_t speed_fly;
    pos_y_t   y_climb;

    // zero counts as falling so a hero at rest can land
    assign falling = (speed_y >= 0);

    // one flying step with ceiling and landing snaps
    always_comb begin
        int ny;
        int top_snap;
        int bot_snap;
        logic top_hit;
        logic bot_hit;
        logic over_x;

        ny = int'(y) + int'(speed_y) / 10;

        top_hit  = ny < int'(border_top);
        top_snap = int'(border_top);
        bot_hit  = ny + int'(hero_height) > int'(border_bottom);
        bot_snap = int'(border_bottom) - int'(hero_height);

        for (int i = 0; i < num_platforms; i++) begin
            over_x = (int'(x) < int'(platform_rx[i])) &&
                     (int'(x) + int'(hero_width) > int'(platform_lx[i]));

            // head enters the platform from below
            if (!top_hit && over_x && ny > int'(platform_ly[i]) &&
                ny < int'(platform_ry[i])) begin
                top_hit  = 1'b1;
                top_snap = int'(platform_ry[i]);
            end

            if (!bot_hit && over_x &&
                ny + int'(hero_height) > int'(platform_ly[i]) &&
                ny + int'(hero_height) < int'(platform_ry[i])) begin
                bot_hit  = 1'b1;
                bot_snap = int'(platform_ly[i]) - int'(hero_height);
            end
        end

        if (top_hit) begin
            y_fly     = pos_y_t'(top_snap);
            speed_fly = '0;
        end else if (bot_hit) begin
            y_fly     = pos_y_t'(bot_snap);
            speed_fly = '0;
        end else begin
            y_fly     = pos_y_t'(ny);
            speed_fly = speed_y + gravity;
        end
    end

    always_comb begin
        if (keys[key_up]) begin
            if (int'(y) - int'(climb_speed) < int'(border_top)) begin
                y_climb = border_top;
            end else begin
                y_climb = y - climb_speed;
            end
        end else if (keys[key_down]) begin
            if (int'(y) + int'(climb_speed) > int'(border_bottom) - int'(hero_height)) begin
                y_climb = border_bottom - hero_height;
            end else begin
                y_climb = y + climb_speed;
            end
        end else begin
            y_climb = y;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || state == st_initial) begin
            y       <= start_y;
            speed_y <= '0;
        end else begin
            case (state)
                st_jumping: speed_y <= -jump_speed;
                st_flying: begin
                    y       <= y_fly;
                    speed_y <= speed_fly;
                end
                st_climbing: begin
                    y       <= y_climb;
                    speed_y <= '0;
                end
                default: speed_y <= '0;
            endcase
        end
    end

    a_y_in_screen: assert property (
        @(posedge clk) disable iff (rst)
        (y >= border_top) && (y <= border_bottom - hero_height)
    );

endmodule

`default_nettype wire

/* rtl/scene/scene_map.sv */
`default_nettype none

module scene_map (
    input  wire mario_pkg::pos_x_t x,
    input  wire mario_pkg::pos_y_t y,
    output logic                   blocked_left,
    output logic                   blocked_right,
    output logic                   on_ground,
    output logic                   on_ladder
);
    import mario_pkg::*;

    // platform contacts and borders
    always_comb begin
        int left_x;
        int right_x;
        int top_y;
        int bottom_y;
        logic span_x;
        logic span_y;

        left_x   = int'(x);
        right_x  = int'(x) + int'(hero_width);
        top_y    = int'(y);
        bottom_y = int'(y) + int'(hero_height);

        blocked_left  = left_x <= int'(border_left);
        blocked_right = right_x >= int'(border_right);
        on_ground     = bottom_y >= int'(border_bottom);

        for (int i = 0; i < num_platforms; i++) begin
            span_y = (top_y < int'(platform_ry[i])) && (bottom_y > int'(platform_ly[i]));
            span_x = (left_x < int'(platform_rx[i])) && (right_x > int'(platform_lx[i]));

            // side contact needs the box level with the platform
            if (span_y && left_x >= int'(platform_lx[i]) &&
                left_x <= int'(platform_rx[i])) begin
                blocked_left = 1'b1;
            end
            if (span_y && right_x >= int'(platform_lx[i]) &&
                right_x <= int'(platform_rx[i])) begin
                blocked_right = 1'b1;
            end

            // feet inside the top band
            if (span_x && bottom_y >= int'(platform_ly[i]) &&
                bottom_y <= int'(platform_ry[i])) begin
                on_ground = 1'b1;
            end
        end
    end

    // ladder test uses the top-left corner only
    always_comb begin
        int corner_x;
        int corner_y;

        corner_x  = int'(x);
        corner_y  = int'(y);
        on_ladder = 1'b0;

        for (int i = 0; i < num_ladders; i++) begin
            if (corner_x > int'(ladder_lx[i]) && corner_x < int'(ladder_rx[i]) &&
                corner_y > int'(ladder_ly[i]) && corner_y < int'(ladder_ry[i])) begin
                on_ladder = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it and scan the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f verilog.f \
    --top-module tb_mario \
    -Mdir obj_dir \
    -o Vtb_mario

./obj_dir/Vtb_mario | tee sim.log

if grep -q "\*\*\* FAILED \*\*\*" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

echo "simulation finished without failure"

/* testbench/tb_mario_model.svh */
`ifndef TB_MARIO_MODEL_SVH
`define TB_MARIO_MODEL_SVH

// reference model of the hero motion, used inside tb_mario

function automatic int unsigned lcg_next(input int unsigned seed);
    return seed * 32'd1103515245 + 32'd12345;
endfunction

function automatic int clamp_x(input int nx);
    int lo;
    int hi;
    lo = int'(border_left);
    hi = int'(border_right) - int'(hero_width);
    if (nx < lo) begin
        return lo;
    end
    return (nx > hi) ? hi : nx;
endfunction

// left wins over right
function automatic int key_step(input logic left, input logic right);
    if (left) begin
        return -int'(walk_speed);
    end
    return right ? int'(walk_speed) : 0;
endfunction

function automatic int walk_next_x(input int px, input logic left, input logic right);
    return clamp_x(px + key_step(left, right));
endfunction

function automatic int climb_next_y(input int py, input logic up, input logic down);
    int lo;
    int hi;
    lo = int'(border_top);
    hi = int'(border_bottom) - int'(hero_height);
    if (up) begin
        return (py - int'(climb_speed) < lo) ? lo : py - int'(climb_speed);
    end
    if (down) begin
        return (py + int'(climb_speed) > hi) ? hi : py + int'(climb_speed);
    end
    return py;
endfunction

// top-left corner strictly inside a ladder
function automatic logic inside_ladder(input int px, input int py);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < num_ladders; i++) begin
        if (px > int'(ladder_lx[i]) && px < int'(ladder_rx[i]) &&
            py > int'(ladder_ly[i]) && py < int'(ladder_ry[i])) begin
            hit = 1'b1;
        end
    end
    return hit;
endfunction

// walking steps to the right until a ladder is reached, -1 if never
function automatic int ladder_walk_count(input int px, input int py);
    int count;
    count = -1;
    for (int k = 0; k < 220; k++) begin
        if (count < 0 && inside_ladder(px, py)) begin
            count = k;
        end
        px = walk_next_x(px, 1'b0, 1'b1);
    end
    return count;
endfunction

// one step of the jump arc, ceiling before floor
function automatic int fly_next_y(input int px, input int py, input int vy);
    int ny;
    int ny_bot;
    int result;
    logic hit;
    logic over_x;
    ny     = py + vy / 10;
    ny_bot = ny + int'(hero_height);
    result = ny;
    hit    = ny < int'(border_top);
    if (hit) begin
        result = int'(border_top);
    end
    for (int i = 0; i < num_platforms; i++) begin
        over_x = px < int'(platform_rx[i]) && px + int'(hero_width) > int'(platform_lx[i]);
        if (!hit && over_x && ny > int'(platform_ly[i]) && ny < int'(platform_ry[i])) begin
            hit    = 1'b1;
            result = int'(platform_ry[i]);
        end
    end
    if (!hit && ny_bot > int'(border_bottom)) begin
        hit    = 1'b1;
        result = int'(border_bottom) - int'(hero_height);
    end
    for (int i = 0; i < num_platforms; i++) begin
        over_x = px < int'(platform_rx[i]) && px + int'(hero_width) > int'(platform_lx[i]);
        if (!hit && over_x && ny_bot > int'(platform_ly[i]) &&
            ny_bot < int'(platform_ry[i])) begin
            hit    = 1'b1;
            result = int'(platform_ly[i]) - int'(hero_height);
        end
    end
    return result;
endfunction

// a snap never lands on the unclamped step, so a snap means speed 0
function automatic int fly_next_vy(input int py, input int vy, input int y_next);
    return (y_next == py + vy / 10) ? vy + int'(gravity) : 0;
endfunction

`endif

/* testbench/tb_mario.sv */
`default_nettype none

module tb_mario;
    timeunit 1ns;
    timeprecision 1ps;

    import mario_pkg::*;

    `include "tb_mario_model.svh"

    localparam int reset_cycles = 16;
    localparam int test_cycles  = 4 + 210 + 80 + 130 + 12;
    localparam int max_cycles   = 2 * test_cycles + reset_cycles;
    localparam int flight_limit = 80;

    logic          clk;
    logic          rst;
    logic          start;
    logic          over;
    key_vec_t      keys;
    pos_x_t        x;
    pos_y_t        y;
    motion_state_t state;

    key_vec_t      edge_keys;
    logic          edge_rst = 1'b0;
    logic          model_on = 1'b0;
    motion_state_t prev_state;
    int            prev_x;
    int            prev_y;
    int            exp_x;
    int            exp_y;
    int            model_vx = 0;
    int            model_vy = 0;
    int            model_errors = 0;
    int            check_errors = 0;
    int            test_base = 0;
    int            tests_run = 0;
    int            tests_failed = 0;
    int            cycle_count = 0;
    int unsigned   rng = 62;
    // hero position as the tests expect it between tests
    int            hero_x;
    int            hero_y;

    mario_top mario_top_inst (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .over  (over),
        .keys  (keys),
        .x     (x),
        .y     (y),
        .state (state)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // inputs as seen by the DUT at the rising edge
    always @(posedge clk) begin
        edge_keys <= keys;
        edge_rst  <= rst;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == max_cycles) begin
            $display("timeout: tests still running after %0d cycles", max_cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // per-cycle position check against the model
    always @(negedge clk) begin
        if (edge_rst) begin
            exp_x    = int'(start_x);
            exp_y    = int'(start_y);
            model_vx = 0;
            model_vy = 0;
            model_on = 1'b1;
        end else if (model_on) begin
            exp_x = prev_x;
            exp_y = prev_y;
            case (prev_state)
                st_initial: begin
                    exp_x    = int'(start_x);
                    exp_y    = int'(start_y);
                    model_vx = 0;
                    model_vy = 0;
                end
                st_walking: begin
                    model_vx = key_step(edge_keys[key_left], edge_keys[key_right]);
                    exp_x    = walk_next_x(prev_x, edge_keys[key_left], edge_keys[key_right]);
                    model_vy = 0;
                end
                st_flying: begin
                    exp_x    = clamp_x(prev_x + model_vx);
                    exp_y    = fly_next_y(prev_x, prev_y, model_vy);
                    model_vy = fly_next_vy(prev_y, model_vy, exp_y);
                end
                st_jumping: begin
                    model_vx = 0;
                    model_vy = -int'(jump_speed);
                end
                st_climbing: begin
                    exp_y    = climb_next_y(prev_y, edge_keys[key_up], edge_keys[key_down]);
                    model_vx = 0;
                    model_vy = 0;
                end
                default: begin
                    model_vx = 0;
                    model_vy = 0;
                end
            endcase
        end
        if (model_on && x !== pos_x_t'(exp_x)) begin
            $display("** Error at %0d ns: x = %0d, expected %0d", $time, x, exp_x);
            model_errors = model_errors + 1;
        end
        if (model_on && y !== pos_y_t'(exp_y)) begin
            $display("** Error at %0d ns: y = %0d, expected %0d", $time, y, exp_y);
            model_errors = model_errors + 1;
        end
        prev_state = state;
        prev_x     = int'(x);
        prev_y     = int'(y);
    end

    function automatic int pick(input int lo, input int hi);
        int r;
        rng = lcg_next(rng);
        r   = int'(rng >> 16);
        return lo + r % (hi - lo + 1);
    endfunction

    task automatic check_state(input motion_state_t want);
        if (state !== want) begin
            $display("** Error at %0d ns: state = %s, expected %s", $time, state.name(),
                     want.name());
            check_errors = check_errors + 1;
        end
    endtask

    task automatic check_pos(input int want_x, input int want_y);
        if (x !== pos_x_t'(want_x)) begin
            $display("** Error at %0d ns: x = %0d, expected %0d", $time, x, want_x);
            check_errors = check_errors + 1;
        end
        if (y !== pos_y_t'(want_y)) begin
            $display("** Error at %0d ns: y = %0d, expected %0d", $time, y, want_y);
            check_errors = check_errors + 1;
        end
    endtask

    task automatic close_test(input string name);
        int found;
        // model errors of the last falling edge are counted by the next rising edge
        @(posedge clk);
        found     = model_errors + check_errors - test_base;
        test_base = model_errors + check_errors;
        tests_run = tests_run + 1;
        if (found > 0) begin
            tests_failed = tests_failed + 1;
            $display("test %s: failed with %0d errors", name, found);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    task automatic reset_and_start();
        @(negedge clk);
        check_state(st_initial);
        check_pos(int'(start_x), int'(start_y));
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_state(st_standing);
        check_pos(int'(start_x), int'(start_y));
        hero_x = int'(start_x);
        hero_y = int'(start_y);
        close_test("reset and start");
    endtask

    task automatic walk_left_and_clamp();
        int hold;
        int want_x;
        @(negedge clk);
        hold   = pick(10, 40);
        want_x = hero_x;
        // first edge only changes the state
        for (int k = 1; k < hold; k++) begin
            want_x = walk_next_x(want_x, 1'b1, 1'b0);
        end
        keys           = '0;
        keys[key_left] = 1'b1;
        repeat (hold) @(negedge clk);
        check_state(st_walking);
        check_pos(want_x, hero_y);
        repeat (160) @(negedge clk);
        check_pos(int'(border_left), hero_y);
        keys = '0;
        @(negedge clk);
        check_state(st_standing);
        repeat (3) @(negedge clk);
        check_state(st_standing);
        check_pos(int'(border_left), hero_y);
        hero_x = int'(border_left);
        close_test("walk left and clamp");
    endtask

    task automatic climb_ladder();
        int steps;
        int rise;
        int ladder_x;
        int y0;
        @(negedge clk);
        ladder_x = hero_x;
        y0       = hero_y;
        steps    = ladder_walk_count(ladder_x, y0);
        if (steps < 0) begin
            $display("no ladder reachable walking right from x %0d", ladder_x);
            check_errors = check_errors + 1;
        end else begin
            for (int k = 0; k < steps; k++) begin
                ladder_x = walk_next_x(ladder_x, 1'b0, 1'b1);
            end
            keys            = '0;
            keys[key_right] = 1'b1;
            repeat (steps + 1) @(negedge clk);
            keys = '0;
            @(negedge clk);
            check_state(st_standing);
            check_pos(ladder_x, y0);
            rise         = pick(8, 23);
            keys[key_up] = 1'b1;
            repeat (rise + 1) @(negedge clk);
            check_state(st_climbing);
            check_pos(ladder_x, y0 - rise * int'(climb_speed));
            keys           = '0;
            keys[key_down] = 1'b1;
            repeat (rise) @(negedge clk);
            check_pos(ladder_x, y0);
            keys = '0;
            repeat (3) @(negedge clk);
            check_state(st_climbing);
            check_pos(ladder_x, y0);
            hero_x = ladder_x;
        end
        close_test("climb ladder");
    endtask

    task automatic jump_and_land();
        int walk;
        int flight;
        int x0;
        @(negedge clk);
        walk = pick(10, 40);
        x0   = hero_x;
        for (int k = 0; k < walk; k++) begin
            x0 = walk_next_x(x0, 1'b0, 1'b1);
        end
        if (inside_ladder(x0, hero_y)) begin
            $display("jump start at x %0d lies on a ladder", x0);
            check_errors = check_errors + 1;
        end
        keys            = '0;
        keys[key_right] = 1'b1;
        repeat (walk + 1) @(negedge clk);
        keys = '0;
        @(negedge clk);
        check_state(st_standing);
        check_pos(x0, hero_y);
        keys[key_jump] = 1'b1;
        @(negedge clk);
        keys = '0;
        check_state(st_jumping);
        @(negedge clk);
        check_state(st_flying);
        flight = 0;
        while (state == st_flying && flight < flight_limit) begin
            @(negedge clk);
            flight = flight + 1;
        end
        if (state == st_flying) begin
            $display("flight did not end within %0d cycles", flight_limit);
            check_errors = check_errors + 1;
        end
        check_state(st_standing);
        check_pos(x0, int'(start_y));
        hero_x = x0;
        hero_y = int'(start_y);
        close_test("jump arc");
    endtask

    task automatic die_and_reset();
        int fx;
        int fy;
        @(negedge clk);
        // the edge that sees over still takes one walking step
        fx              = walk_next_x(hero_x, 1'b0, 1'b1);
        fy              = hero_y;
        keys            = '0;
        keys[key_right] = 1'b1;
        @(negedge clk);
        check_state(st_walking);
        check_pos(hero_x, hero_y);
        over = 1'b1;
        @(negedge clk);
        over = 1'b0;
        check_state(st_dying);
        check_pos(fx, fy);
        keys = '1;
        repeat (5) @(negedge clk);
        check_state(st_dying);
        check_pos(fx, fy);
        keys = '0;
        rst  = 1'b1;
        @(negedge clk);
        rst = 1'b0;
        check_state(st_initial);
        check_pos(int'(start_x), int'(start_y));
        close_test("die and reset");
    endtask

    initial begin
        rst   = 1'b1;
        start = 1'b0;
        over  = 1'b0;
        keys  = '0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        reset_and_start();
        walk_left_and_clamp();
        climb_ladder();
        jump_and_land();
        die_and_reset();

        $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
                 model_errors + check_errors);
        if (model_errors + check_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+testbench
common/mario_pkg.sv
rtl/scene/scene_map.sv
rtl/motion_fsm.sv
rtl/physics/vertical_motion.sv
rtl/physics/horizontal_motion.sv
rtl/mario_top.sv
testbench/tb_mario.sv
